//--- lz77_engine.sv
module lz77_engine (
   input  logic                clk,
   input  logic                rst_n,
   input  lz77_pkg::lz_in_t    in_beat,
   input  logic                in_valid,
   output logic                in_ready,
   input  lz77_pkg::lz_cfg_t   cfg,
   output lz77_pkg::lz_token_t token,
   output logic                token_valid,
   input  logic                token_ready
);

   import lz77_pkg::*;

   lz_in_t     stage_beat;
   logic       stage_valid;
   logic       stage_ready;
   lz_cfg_t    block_cfg;    // Frozen per block.
   logic       block_done;
   lz_byte_t   cur_byte;
   logic       shift;
   logic       clear;
   cand_mask_t eq_mask;

   lz77_input_stage u_input_stage (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_beat     (in_beat),
      .in_valid    (in_valid),
      .in_ready    (in_ready),
      .cfg         (cfg),
      .stage_beat  (stage_beat),
      .stage_valid (stage_valid),
      .stage_ready (stage_ready),
      .block_done  (block_done),
      .block_cfg   (block_cfg)
   );

   lz77_history_window u_history_window (
      .clk       (clk),
      .rst_n     (rst_n),
      .cur_byte  (cur_byte),
      .shift     (shift),
      .clear     (clear),
      .block_cfg (block_cfg),
      .eq_mask   (eq_mask)
   );

   lz77_match_tracker u_match_tracker (
      .clk         (clk),
      .rst_n       (rst_n),
      .stage_beat  (stage_beat),
      .stage_valid (stage_valid),
      .stage_ready (stage_ready),
      .block_cfg   (block_cfg),
      .eq_mask     (eq_mask),
      .cur_byte    (cur_byte),
      .shift       (shift),
      .clear       (clear),
      .token       (token),
      .token_valid (token_valid),
      .token_ready (token_ready),
      .block_done  (block_done)
   );

endmodule

//--- lz77_history_window.sv
module lz77_history_window (
   input  logic                 clk,
   input  logic                 rst_n,
   input  lz77_pkg::lz_byte_t   cur_byte,
   input  logic                 shift,
   input  logic                 clear,
   input  lz77_pkg::lz_cfg_t    block_cfg,
   output lz77_pkg::cand_mask_t eq_mask
);

   import lz77_pkg::*;

   lz_byte_t [win_offsets-1:0] hist_q;   // Entry 0 is the newest byte.
   offset_t                    fill_q;   // Bytes seen this block.
   offset_t                    limit;

   assign limit = win_limit(block_cfg.win_code);

   always_ff @(posedge clk) begin
      if (shift) begin
         hist_q <= {hist_q[win_offsets-2:0], cur_byte};
      end
   end

   // Saturates at the full depth.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fill_q <= '0;
      end else if (clear) begin
         fill_q <= '0;
      end else if (shift && (fill_q < offset_t'(win_offsets))) begin
         fill_q <= fill_q + 1'b1;
      end
   end

   always_comb begin
      for (int d = 1; d <= win_offsets; d++) begin
         eq_mask[d-1] = (hist_q[d-1] == cur_byte)
                        && (offset_t'(d) <= limit)
                        && (offset_t'(d) <= fill_q);
      end
   end

   // Stale history never reaches the tracker.
   a_mask_fill : assert property (@(posedge clk) disable iff (!rst_n)
      (eq_mask >> fill_q) == '0);

endmodule

//--- lz77_input_stage.sv
module lz77_input_stage (
   input  logic              clk,
   input  logic              rst_n,
   input  lz77_pkg::lz_in_t  in_beat,
   input  logic              in_valid,
   output logic              in_ready,
   input  lz77_pkg::lz_cfg_t cfg,
   output lz77_pkg::lz_in_t  stage_beat,
   output logic              stage_valid,
   input  logic              stage_ready,
   input  logic              block_done,
   output lz77_pkg::lz_cfg_t block_cfg
);

   logic full_q;   // Slot holds a beat.
   logic hold_q;   // Block in progress.
   logic tail_q;   // Last beat taken, block still draining.
   logic accept;

   // Next block waits until the previous one has drained.
   assign in_ready    = !tail_q && (!full_q || stage_ready);
   assign accept      = in_valid && in_ready;
   assign stage_valid = full_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         full_q <= 1'b0;
      end else if (accept) begin
         full_q <= 1'b1;
      end else if (stage_ready) begin
         full_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         stage_beat <= in_beat;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hold_q    <= 1'b0;
         tail_q    <= 1'b0;
         block_cfg <= '0;
      end else begin
         if (!hold_q) begin
            block_cfg <= cfg;   // Tracks cfg between blocks.
         end
         if (block_done) begin
            hold_q <= 1'b0;
            tail_q <= 1'b0;
         end else if (accept) begin
            hold_q <= 1'b1;
            if (in_beat.last) begin
               tail_q <= 1'b1;
            end
         end
      end
   end

   // Window and tracker see one configuration for the whole block.
   a_cfg_hold : assert property (@(posedge clk) disable iff (!rst_n)
      (stage_valid || tail_q) |=> $stable(block_cfg));

endmodule

//--- lz77_match_tracker.sv
module lz77_match_tracker (
   input  logic                 clk,
   input  logic                 rst_n,
   input  lz77_pkg::lz_in_t     stage_beat,
   input  logic                 stage_valid,
   output logic                 stage_ready,
   input  lz77_pkg::lz_cfg_t    block_cfg,
   input  lz77_pkg::cand_mask_t eq_mask,
   output lz77_pkg::lz_byte_t   cur_byte,
   output logic                 shift,
   output logic                 clear,
   output lz77_pkg::lz_token_t  token,
   output logic                 token_valid,
   input  logic                 token_ready,
   output logic                 block_done
);

   import lz77_pkg::*;

   typedef enum logic [1:0] {
      st_idle,
      st_run,
      st_flush
   } state_t;

   state_t     state_q;
   state_t     state_n;
   cand_mask_t cand_q;
   cand_mask_t cand_n;
   cand_mask_t survive;
   length_t    len_q;
   length_t    len_n;
   lz_byte_t   lit0_q;
   lz_byte_t   lit1_q;
   lz_byte_t   lit0_n;
   lz_byte_t   lit1_n;
   logic       tok_free;
   logic       consume;
   logic       extend;
   logic       closing;
   logic       flush_go;
   logic       load;
   lz_token_t  tok_n;

   // Smallest surviving offset wins.
   function automatic offset_t lowest_offset(cand_mask_t cand);
      offset_t off;
      off = '0;
      for (int d = win_offsets; d >= 1; d--) begin
         if (cand[d-1]) begin
            off = offset_t'(d);
         end
      end
      return off;
   endfunction

   function automatic lz_token_t build_token(length_t len, cand_mask_t cand,
                                             lz_byte_t b0, lz_byte_t b1, logic last);
      lz_token_t t;
      t      = '0;
      t.last = last;
      if (len >= length_t'(min_match)) begin
         t.kind   = tok_pointer;
         t.offset = lowest_offset(cand);
         t.length = len;
      end else begin
         t.kind      = tok_literal;
         t.lit_count = len[1:0];
         t.lit0      = b0;
         t.lit1      = (len == length_t'(2)) ? b1 : '0;
      end
      return t;
   endfunction

   assign tok_free    = !token_valid || token_ready;
   assign stage_ready = (state_q != st_flush) && tok_free;
   assign consume     = stage_valid && stage_ready;
   assign flush_go    = (state_q == st_flush) && tok_free;
   assign cur_byte    = stage_beat.data;
   assign shift       = consume;
   assign clear       = consume && stage_beat.last;   // History ends with the block.
   assign block_done  = token_valid && token_ready && token.last;

   assign survive = cand_q & eq_mask;
   assign extend  = (state_q == st_run) && (|survive)
                    && (len_q < len_limit(block_cfg.len_code));
   assign closing = consume && (state_q == st_run) && !extend;

   // Run as it stands once the byte is taken.
   assign cand_n = extend ? survive : eq_mask;
   assign len_n  = extend ? len_q + 1'b1 : length_t'(1);
   assign lit0_n = extend ? lit0_q : cur_byte;
   assign lit1_n = (extend && (len_q == length_t'(1))) ? cur_byte : lit1_q;

   always_comb begin
      tok_n   = build_token(len_n, cand_n, lit0_n, lit1_n, 1'b1);
      load    = 1'b0;
      state_n = state_q;
      if (flush_go) begin
         tok_n   = build_token(length_t'(1), '0, lit0_q, '0, 1'b1);
         load    = 1'b1;
         state_n = st_idle;
      end else if (consume) begin
         if (closing) begin
            tok_n = build_token(len_q, cand_q, lit0_q, lit1_q, 1'b0);
            load  = 1'b1;
         end else if (stage_beat.last) begin
            load = 1'b1;   // Run ends with the block.
         end
         if (!stage_beat.last) begin
            state_n = st_run;
         end else if (closing) begin
            state_n = st_flush;   // Closing byte still owes a literal.
         end else begin
            state_n = st_idle;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q     <= st_idle;
         cand_q      <= '0;
         len_q       <= '0;
         token_valid <= 1'b0;
      end else begin
         state_q <= state_n;
         if (consume) begin
            cand_q <= cand_n;
            len_q  <= len_n;
         end
         if (load) begin
            token_valid <= 1'b1;
         end else if (token_ready) begin
            token_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (consume) begin
         lit0_q <= lit0_n;
         lit1_q <= lit1_n;
      end
      if (load) begin
         token <= tok_n;
      end
   end

   a_tok_hold : assert property (@(posedge clk) disable iff (!rst_n)
      token_valid && !token_ready |=> token_valid && $stable(token));

   a_lit_count : assert property (@(posedge clk) disable iff (!rst_n)
      token_valid && (token.kind == tok_literal) |-> token.lit_count inside {2'd1, 2'd2});

   // Held block configuration bounds every pointer of the block.
   a_ptr_offset : assert property (@(posedge clk) disable iff (!rst_n)
      token_valid && (token.kind == tok_pointer)
      |-> (token.offset != '0) && (token.offset <= win_limit(block_cfg.win_code)));

endmodule

//--- lz77_pkg.sv
package lz77_pkg;

   localparam int win_offsets = 16;   // Deepest history.
   localparam int max_run     = 63;
   localparam int min_match   = 3;    // Shorter runs go out as literals.

   typedef logic [7:0]             lz_byte_t;
   typedef logic [4:0]             offset_t;
   typedef logic [5:0]             length_t;
   typedef logic [win_offsets-1:0] cand_mask_t;   // Bit d-1 is offset d.
   typedef logic [1:0]             win_code_t;
   typedef logic [1:0]             len_code_t;

   typedef enum logic {
      tok_literal,
      tok_pointer
   } token_kind_t;

   typedef struct packed {
      lz_byte_t data;
      logic     last;
   } lz_in_t;

   typedef struct packed {
      win_code_t win_code;
      len_code_t len_code;
   } lz_cfg_t;

   typedef struct packed {
      token_kind_t kind;
      logic [1:0]  lit_count;
      lz_byte_t    lit0;        // Older byte.
      lz_byte_t    lit1;
      offset_t     offset;
      length_t     length;
      logic        last;
   } lz_token_t;

   function automatic offset_t win_limit(win_code_t code);
      case (code)
         2'd0:    return offset_t'(4);
         2'd1:    return offset_t'(8);
         default: return offset_t'(win_offsets);   // Code 3 acts as 16.
      endcase
   endfunction

   function automatic length_t len_limit(len_code_t code);
      case (code)
         2'd0:    return length_t'(8);
         2'd1:    return length_t'(16);
         2'd2:    return length_t'(32);
         default: return length_t'(max_run);
      endcase
   endfunction

endpackage

//--- lz77_stimulus.txt
# C win_code len_code / B data last / E kind lit_count lit0 lit1 offset length last
# Hex fields; kind 0 is a literal token, 1 a pointer token.
C 2 3
B 0a 0
B 0b 0
B 0a 0
B 0b 0
B 0c 1
E 0 1 0a 00 00 00 0
E 0 1 0b 00 00 00 0
E 0 2 0a 0b 00 00 0
E 0 1 0c 00 00 00 1
C 2 3
B 01 0
B 02 0
B 03 0
B 01 0
B 02 0
B 03 0
B 09 0
B 01 0
B 02 0
B 03 1
E 0 1 01 00 00 00 0
E 0 1 02 00 00 00 0
E 0 1 03 00 00 00 0
E 1 0 00 00 03 03 0
E 0 1 09 00 00 00 0
E 1 0 00 00 04 03 1
C 2 0
B aa 0
B aa 0
B aa 0
B aa 0
B aa 0
B aa 0
B aa 0
B aa 0
B aa 0
B aa 1
E 0 1 aa 00 00 00 0
E 1 0 00 00 01 08 0
E 0 1 aa 00 00 00 1
C 0 3
B 11 0
B 12 0
B 13 0
B 14 0
B 15 0
B 16 0
B 11 0
B 12 1
E 0 1 11 00 00 00 0
E 0 1 12 00 00 00 0
E 0 1 13 00 00 00 0
E 0 1 14 00 00 00 0
E 0 1 15 00 00 00 0
E 0 1 16 00 00 00 0
E 0 1 11 00 00 00 0
E 0 1 12 00 00 00 1
C 1 3
B 11 0
B 12 0
B 13 0
B 14 0
B 15 0
B 16 0
B 11 0
B 12 0
B 13 1
E 0 1 11 00 00 00 0
E 0 1 12 00 00 00 0
E 0 1 13 00 00 00 0
E 0 1 14 00 00 00 0
E 0 1 15 00 00 00 0
E 0 1 16 00 00 00 0
E 1 0 00 00 06 03 1

//--- run.sh
#!/bin/sh
set -e
verilator --binary --timing --assert -f tb.f --top-module tb_lz77_engine -o sim_lz77
./obj_dir/sim_lz77 > sim.log 2>&1 || true
cat sim.log
if grep -q "RESULT: FAIL" sim.log; then
   echo "Simulation failed"
   exit 1
fi
echo "Simulation finished without failure"

//--- tb.f
lz77_pkg.sv
lz77_input_stage.sv
lz77_history_window.sv
lz77_match_tracker.sv
lz77_engine.sv
tb_lz77_engine.sv

//--- tb_lz77_engine.sv
module tb_lz77_engine;

   import lz77_pkg::*;

   logic      clk;
   logic      rst_n;
   lz_in_t    in_beat;
   logic      in_valid;
   logic      in_ready;
   lz_cfg_t   cfg;
   lz_token_t token;
   logic      token_valid;
   logic      token_ready;

   lz_in_t    beat_q[$];
   logic      first_q[$];    // Beat opens a block.
   lz_cfg_t   beat_cfg_q[$];
   lz_token_t exp_q[$];
   int        errors;
   int        seed;
   int        bi;
   int        tokens_seen;
   logic      sent;
   logic      loaded;

   lz77_engine dut (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_beat     (in_beat),
      .in_valid    (in_valid),
      .in_ready    (in_ready),
      .cfg         (cfg),
      .token       (token),
      .token_valid (token_valid),
      .token_ready (token_ready)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic load_stimulus();
      int      fd;
      int      n;
      int      a;
      int      b;
      int      f[7];
      string   line;
      lz_cfg_t cur_cfg;
      logic    next_first;
      lz_in_t  beat;
      lz_token_t t;
      cur_cfg    = '0;
      next_first = 1'b1;
      fd = $fopen("lz77_stimulus.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("Cannot open the stimulus file lz77_stimulus.txt");
      end else begin
         while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line[0] == "C") begin
               n = $sscanf(line, "C %h %h", a, b);
               cur_cfg.win_code = a[1:0];
               cur_cfg.len_code = b[1:0];
               next_first       = 1'b1;
            end else if (n > 0 && line[0] == "B") begin
               n = $sscanf(line, "B %h %h", a, b);
               beat.data = a[7:0];
               beat.last = b[0];
               beat_q.push_back(beat);
               first_q.push_back(next_first);
               beat_cfg_q.push_back(cur_cfg);
               next_first = 1'b0;
            end else if (n > 0 && line[0] == "E") begin
               n = $sscanf(line, "E %h %h %h %h %h %h %h",
                           f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
               t.kind      = token_kind_t'(f[0][0]);
               t.lit_count = f[1][1:0];
               t.lit0      = f[2][7:0];
               t.lit1      = f[3][7:0];
               t.offset    = f[4][4:0];
               t.length    = f[5][5:0];
               t.last      = f[6][0];
               exp_q.push_back(t);
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic compare_token();
      lz_token_t e;
      tokens_seen++;
      if (exp_q.size() == 0) begin
         errors++;
         $display("Token at %0t arrived with no expected token left", $time);
      end else begin
         e = exp_q.pop_front();
         check("token.kind", 32'(token.kind), 32'(e.kind));
         check("token.lit_count", 32'(token.lit_count), 32'(e.lit_count));
         check("token.lit0", 32'(token.lit0), 32'(e.lit0));
         check("token.lit1", 32'(token.lit1), 32'(e.lit1));
         check("token.offset", 32'(token.offset), 32'(e.offset));
         check("token.length", 32'(token.length), 32'(e.length));
         check("token.last", 32'(token.last), 32'(e.last));
      end
   endtask

   initial begin
      rst_n       = 1'b0;
      in_beat     = '0;
      in_valid    = 1'b0;
      cfg         = '0;
      token_ready = 1'b0;
      errors      = 0;
      tokens_seen = 0;
      seed        = 39;
      bi          = 0;
      sent        = 1'b0;
      loaded      = 1'b0;
      load_stimulus();
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      #10;
      check("token_valid", 32'(token_valid), 32'd0);
      check("in_ready", 32'(in_ready), 32'd1);
      loaded = 1'b1;
      while (bi < beat_q.size() || exp_q.size() > 0) begin
         @(negedge clk);
         if (sent) begin
            bi++;
            in_valid = 1'b0;
            sent     = 1'b0;
         end
         token_ready = ({$random(seed)} % 4) != 0;
         if (bi < beat_q.size()) begin
            // Later beats see a different cfg, which the block must ignore.
            cfg = first_q[bi] ? beat_cfg_q[bi] : lz_cfg_t'(beat_cfg_q[bi] ^ 4'hf);
            if (!in_valid) begin
               in_valid = ({$random(seed)} % 3) != 0;   // Random gaps.
               in_beat  = beat_q[bi];
            end
         end
         #10;
         if (token_valid && token_ready) begin
            compare_token();
         end
         sent = in_valid && in_ready;
      end
      // Stream must stay quiet once every token is in.
      token_ready = 1'b1;
      repeat (10) begin
         @(negedge clk);
         if (token_valid) begin
            errors++;
            $display("Extra token at %0t after the expected stream ended", $time);
         end
      end
      $display("Done: %0d tokens checked, %0d errors", tokens_seen, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

   // Generous bound per byte for back-pressure and flush cycles.
   initial begin
      wait (loaded);
      repeat (40 * beat_q.size() + 200) @(posedge clk);
      $display("Timeout: the token stream did not complete in time");
      $display("RESULT: FAIL");
      $finish;
   end

endmodule
